// ==== Bender.yml ====
package:
  name: mem_subsys

sources:
  - common/core_pkg.sv
  - ex_me/ex_me.sv
  - mem_stage/mem_access.sv
  - mem_stage/me_wb.sv
  - rtl/stall_ctrl.sv
  - rtl/apb_data_ram.sv
  - rtl/mem_subsys_top.sv
  - target: simulation
    files:
      - tests/tb_mem_subsys.sv

// ==== all.f ====
common/core_pkg.sv
ex_me/ex_me.sv
mem_stage/mem_access.sv
mem_stage/me_wb.sv
rtl/stall_ctrl.sv
rtl/apb_data_ram.sv
rtl/mem_subsys_top.sv
tests/tb_mem_subsys.sv

// ==== common/core_pkg.sv ====
package core_pkg;

	// datapath widths
	localparam int XLEN       = 64;
	localparam int REG_ADDR_W = 5;
	localparam int BE_W       = XLEN / 8;
	localparam int CAUSE_W    = 5;

	// pipeline register control
	typedef enum logic [1:0] {
		STALL_NEXT = 2'b00,
		STALL_KEEP = 2'b01,
		STALL_ZERO = 2'b10
	} stall_op_e;

	// APB master sequencing in the memory stage
	typedef enum logic [1:0] {
		MEM_IDLE   = 2'b00,
		MEM_SETUP  = 2'b01,
		MEM_ACCESS = 2'b10,
		MEM_DONE   = 2'b11
	} mem_state_e;

	// exception causes raised by the memory stage
	localparam logic [CAUSE_W-1:0] CAUSE_LOAD_MISALIGNED  = 5'd4;
	localparam logic [CAUSE_W-1:0] CAUSE_LOAD_FAULT       = 5'd5;
	localparam logic [CAUSE_W-1:0] CAUSE_STORE_MISALIGNED = 5'd6;
	localparam logic [CAUSE_W-1:0] CAUSE_STORE_FAULT      = 5'd7;

	// data RAM geometry, depth in 64-bit words
	localparam int DRAM_WORDS  = 256;
	localparam int DRAM_ADDR_W = $clog2(DRAM_WORDS);

	// pready stays low this many ACCESS cycles
	localparam int DRAM_WAIT   = 2;
	localparam int WAIT_CNT_W  = $clog2(DRAM_WAIT + 2);

endpackage

// ==== ex_me/ex_me.sv ====
`timescale 1ns/1ps

module ex_me import core_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  stall_op_e             stall,

	input  logic                  ex_valid,
	input  logic                  ex_mem_rena,
	input  logic                  ex_mem_wena,
	input  logic                  ex_mem_ext_un,
	input  logic [BE_W-1:0]       ex_mem_byte_enable,
	input  logic [XLEN-1:0]       ex_alu_result,
	input  logic [XLEN-1:0]       ex_rs2_data,
	input  logic                  ex_rd_wena,
	input  logic [REG_ADDR_W-1:0] ex_rd_waddr,
	input  logic [XLEN-1:0]       ex_pc,
	input  logic                  ex_exception_flag,
	input  logic [CAUSE_W-1:0]    ex_exception_cause,

	output logic                  me_valid,
	output logic                  me_mem_rena,
	output logic                  me_mem_wena,
	output logic                  me_mem_ext_un,
	output logic [BE_W-1:0]       me_mem_byte_enable,
	output logic [XLEN-1:0]       me_alu_result,
	output logic [XLEN-1:0]       me_rs2_data,
	output logic                  me_rd_wena,
	output logic [REG_ADDR_W-1:0] me_rd_waddr,
	output logic [XLEN-1:0]       me_pc,
	output logic                  me_exception_flag,
	output logic [CAUSE_W-1:0]    me_exception_cause
);

	// control bits, cleared by reset and by a bubble
	always_ff @(posedge clk) begin
		if (rst) begin
			me_valid          <= 1'b0;
			me_mem_rena       <= 1'b0;
			me_mem_wena       <= 1'b0;
			me_rd_wena        <= 1'b0;
			me_exception_flag <= 1'b0;
		end else if (stall == STALL_NEXT) begin
			me_valid          <= ex_valid;
			me_mem_rena       <= ex_mem_rena;
			me_mem_wena       <= ex_mem_wena;
			me_rd_wena        <= ex_rd_wena;
			me_exception_flag <= ex_exception_flag;
		end else if (stall != STALL_KEEP) begin
			// bubble, unknown codes too
			me_valid          <= 1'b0;
			me_mem_rena       <= 1'b0;
			me_mem_wena       <= 1'b0;
			me_rd_wena        <= 1'b0;
			me_exception_flag <= 1'b0;
		end
	end

	// payload fields
	always_ff @(posedge clk) begin
		if (stall == STALL_NEXT) begin
			me_mem_ext_un      <= ex_mem_ext_un;
			me_mem_byte_enable <= ex_mem_byte_enable;
			me_alu_result      <= ex_alu_result;
			me_rs2_data        <= ex_rs2_data;
			me_rd_waddr        <= ex_rd_waddr;
			me_pc              <= ex_pc;
			me_exception_cause <= ex_exception_cause;
		end else if (stall != STALL_KEEP) begin
			me_pc <= '0;
		end
	end

	// decode upstream never issues a combined load and store
	a_no_rd_and_wr: assert property (@(posedge clk) disable iff (rst)
		!(me_mem_rena && me_mem_wena))
		else $error("ex_me holds a load and a store at once");

endmodule

// ==== mem_stage/me_wb.sv ====
`timescale 1ns/1ps

module me_wb import core_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  stall_op_e             stall,

	input  logic                  me_valid,
	input  logic                  acc_rd_wena,
	input  logic [REG_ADDR_W-1:0] me_rd_waddr,
	input  logic [XLEN-1:0]       acc_rd_wdata,
	input  logic [XLEN-1:0]       me_pc,
	input  logic                  acc_exception_flag,
	input  logic [CAUSE_W-1:0]    acc_exception_cause,

	output logic                  wb_valid,
	output logic                  wb_rd_wena,
	output logic [REG_ADDR_W-1:0] wb_rd_waddr,
	output logic [XLEN-1:0]       wb_rd_wdata,
	output logic [XLEN-1:0]       wb_pc,
	output logic                  wb_exception_flag,
	output logic [CAUSE_W-1:0]    wb_exception_cause
);

	always_ff @(posedge clk) begin
		if (rst) begin
			wb_valid          <= 1'b0;
			wb_rd_wena        <= 1'b0;
			wb_exception_flag <= 1'b0;
		end else if (stall == STALL_NEXT) begin
			wb_valid          <= me_valid;
			wb_rd_wena        <= acc_rd_wena;
			wb_exception_flag <= acc_exception_flag;
		end else if (stall != STALL_KEEP) begin
			wb_valid          <= 1'b0;
			wb_rd_wena        <= 1'b0;
			wb_exception_flag <= 1'b0;
		end
	end

	// result payload
	always_ff @(posedge clk) begin
		if (stall == STALL_NEXT) begin
			wb_rd_waddr        <= me_rd_waddr;
			wb_rd_wdata        <= acc_rd_wdata;
			wb_pc              <= me_pc;
			wb_exception_cause <= acc_exception_cause;
		end else if (stall != STALL_KEEP) begin
			wb_pc <= '0;
		end
	end

endmodule

// ==== mem_stage/mem_access.sv ====
`timescale 1ns/1ps

module mem_access import core_pkg::*; (
	input  logic               clk,
	input  logic               rst,

	input  logic               me_valid,
	input  logic               me_mem_rena,
	input  logic               me_mem_wena,
	input  logic               me_mem_ext_un,
	input  logic [BE_W-1:0]    me_mem_byte_enable,
	input  logic [XLEN-1:0]    me_alu_result,
	input  logic [XLEN-1:0]    me_rs2_data,
	input  logic               me_rd_wena,
	input  logic               me_exception_flag,
	input  logic [CAUSE_W-1:0] me_exception_cause,

	output logic               psel,
	output logic               penable,
	output logic               pwrite,
	output logic [XLEN-1:0]    paddr,
	output logic [XLEN-1:0]    pwdata,
	output logic [BE_W-1:0]    pstrb,
	input  logic [XLEN-1:0]    prdata,
	input  logic               pready,
	input  logic               pslverr,

	output logic               mem_busy,
	output logic               acc_rd_wena,
	output logic [XLEN-1:0]    acc_rd_wdata,
	output logic               acc_exception_flag,
	output logic [CAUSE_W-1:0] acc_exception_cause
);

	mem_state_e      state;
	mem_state_e      state_nxt;
	logic [2:0]      lane;
	logic [3:0]      nbytes;
	logic [15:0]     span;
	logic            aligned;
	logic            mem_req;
	logic            misaligned;
	logic            start;
	logic            fault_q;
	logic [XLEN-1:0] rdata_q;
	logic [XLEN-1:0] lane_data;
	logic [XLEN-1:0] load_data;

	// lowest enabled lane and access width
	always_comb begin
		lane   = '0;
		nbytes = '0;
		for (int i = BE_W - 1; i >= 0; i--) begin
			if (me_mem_byte_enable[i])
				lane = 3'(i);
		end
		for (int i = 0; i < BE_W; i++)
			nbytes = nbytes + 4'(me_mem_byte_enable[i]);
	end

	// mask must be contiguous and naturally aligned
	assign span    = ((16'd1 << nbytes) - 16'd1) << lane;
	assign aligned = (nbytes == 4'd1 || nbytes == 4'd2 || nbytes == 4'd4 || nbytes == 4'd8)
		&& (({1'b0, lane} & (nbytes - 4'd1)) == 4'd0)
		&& (span == {8'd0, me_mem_byte_enable});

	assign mem_req    = me_valid & (me_mem_rena | me_mem_wena);
	assign misaligned = mem_req & ~me_exception_flag & ~aligned;
	assign start      = mem_req & ~me_exception_flag & aligned;

	always_comb begin
		state_nxt = state;
		case (state)
			MEM_IDLE:   if (start) state_nxt = MEM_SETUP;
			MEM_SETUP:  state_nxt = MEM_ACCESS;
			MEM_ACCESS: if (pready) state_nxt = MEM_DONE;
			default:    state_nxt = MEM_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state   <= MEM_IDLE;
			fault_q <= 1'b0;
		end else begin
			state   <= state_nxt;
			// only meaningful in MEM_DONE
			fault_q <= (state == MEM_ACCESS) & pready & pslverr;
		end
	end

	always_ff @(posedge clk) begin
		if (state == MEM_ACCESS && pready)
			rdata_q <= prdata;
	end

	// APB drive, address and data held by ex_me while busy
	assign psel    = (state == MEM_SETUP) | (state == MEM_ACCESS);
	assign penable = (state == MEM_ACCESS);
	assign pwrite  = me_mem_wena;
	assign paddr   = {me_alu_result[XLEN-1:3], 3'b000};
	assign pwdata  = me_rs2_data;
	assign pstrb   = me_mem_byte_enable;

	assign mem_busy = ((state == MEM_IDLE) & start) | psel;

	// load extraction and extension
	assign lane_data = rdata_q >> {lane, 3'b000};
	always_comb begin
		case (nbytes)
			4'd1:    load_data = {{56{~me_mem_ext_un & lane_data[7]}}, lane_data[7:0]};
			4'd2:    load_data = {{48{~me_mem_ext_un & lane_data[15]}}, lane_data[15:0]};
			4'd4:    load_data = {{32{~me_mem_ext_un & lane_data[31]}}, lane_data[31:0]};
			default: load_data = lane_data;
		endcase
	end

	// an earlier exception keeps its cause
	always_comb begin
		acc_exception_flag = me_exception_flag | misaligned | fault_q;
		if (me_exception_flag)
			acc_exception_cause = me_exception_cause;
		else if (misaligned)
			acc_exception_cause = me_mem_wena ? CAUSE_STORE_MISALIGNED : CAUSE_LOAD_MISALIGNED;
		else
			acc_exception_cause = me_mem_wena ? CAUSE_STORE_FAULT : CAUSE_LOAD_FAULT;
	end

	assign acc_rd_wena  = me_rd_wena & ~acc_exception_flag;
	assign acc_rd_wdata = me_mem_rena ? load_data : me_alu_result;

	a_paddr_stable: assert property (@(posedge clk) disable iff (rst)
		psel && !pready |=> $stable(paddr))
		else $error("paddr changed during an APB transfer");

endmodule

// ==== rtl/apb_data_ram.sv ====
`timescale 1ns/1ps

module apb_data_ram import core_pkg::*; (
	input  logic            clk,
	input  logic            rst,
	input  logic            psel,
	input  logic            penable,
	input  logic            pwrite,
	input  logic [XLEN-1:0] paddr,
	input  logic [XLEN-1:0] pwdata,
	input  logic [BE_W-1:0] pstrb,
	output logic [XLEN-1:0] prdata,
	output logic            pready,
	output logic            pslverr
);

	logic [XLEN-1:0]        mem [DRAM_WORDS];
	logic [WAIT_CNT_W-1:0]  wait_cnt;
	logic [DRAM_ADDR_W-1:0] word_idx;
	logic                   access;
	logic                   out_of_range;

	assign access       = psel & penable;
	assign word_idx     = paddr[DRAM_ADDR_W+2:3];
	// anything above the last word
	assign out_of_range = |paddr[XLEN-1:DRAM_ADDR_W+3];

	assign pready  = access & (wait_cnt == WAIT_CNT_W'(DRAM_WAIT));
	assign pslverr = pready & out_of_range;
	assign prdata  = (pready & ~pwrite & ~out_of_range) ? mem[word_idx] : '0;

	// wait states counted inside ACCESS only
	always_ff @(posedge clk) begin
		if (rst)
			wait_cnt <= '0;
		else if (!access || pready)
			wait_cnt <= '0;
		else
			wait_cnt <= wait_cnt + 1'b1;
	end

	// byte lane writes
	always_ff @(posedge clk) begin
		if (pready && pwrite && !out_of_range) begin
			for (int b = 0; b < BE_W; b++) begin
				if (pstrb[b])
					mem[word_idx][b*8 +: 8] <= pwdata[b*8 +: 8];
			end
		end
	end

endmodule

// ==== rtl/mem_subsys_top.sv ====
`timescale 1ns/1ps

module mem_subsys_top import core_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,

	input  logic                  ex_valid,
	input  logic                  ex_mem_rena,
	input  logic                  ex_mem_wena,
	input  logic                  ex_mem_ext_un,
	input  logic [BE_W-1:0]       ex_mem_byte_enable,
	input  logic [XLEN-1:0]       ex_alu_result,
	input  logic [XLEN-1:0]       ex_rs2_data,
	input  logic                  ex_rd_wena,
	input  logic [REG_ADDR_W-1:0] ex_rd_waddr,
	input  logic [XLEN-1:0]       ex_pc,
	input  logic                  ex_exception_flag,
	input  logic [CAUSE_W-1:0]    ex_exception_cause,
	input  logic                  flush,
	output logic                  ex_hold,

	output logic                  wb_valid,
	output logic                  wb_rd_wena,
	output logic [REG_ADDR_W-1:0] wb_rd_waddr,
	output logic [XLEN-1:0]       wb_rd_wdata,
	output logic [XLEN-1:0]       wb_pc,
	output logic                  wb_exception_flag,
	output logic [CAUSE_W-1:0]    wb_exception_cause
);

	stall_op_e             ex_me_stall;
	stall_op_e             me_wb_stall;
	logic                  mem_busy;

	logic                  me_valid;
	logic                  me_mem_rena;
	logic                  me_mem_wena;
	logic                  me_mem_ext_un;
	logic [BE_W-1:0]       me_mem_byte_enable;
	logic [XLEN-1:0]       me_alu_result;
	logic [XLEN-1:0]       me_rs2_data;
	logic                  me_rd_wena;
	logic [REG_ADDR_W-1:0] me_rd_waddr;
	logic [XLEN-1:0]       me_pc;
	logic                  me_exception_flag;
	logic [CAUSE_W-1:0]    me_exception_cause;

	logic                  acc_rd_wena;
	logic [XLEN-1:0]       acc_rd_wdata;
	logic                  acc_exception_flag;
	logic [CAUSE_W-1:0]    acc_exception_cause;

	// APB between the memory stage and the RAM
	logic                  psel;
	logic                  penable;
	logic                  pwrite;
	logic [XLEN-1:0]       paddr;
	logic [XLEN-1:0]       pwdata;
	logic [BE_W-1:0]       pstrb;
	logic [XLEN-1:0]       prdata;
	logic                  pready;
	logic                  pslverr;

	stall_ctrl u_stall_ctrl (
		.clk         (clk),
		.rst         (rst),
		.mem_busy    (mem_busy),
		.flush       (flush),
		.ex_me_stall (ex_me_stall),
		.me_wb_stall (me_wb_stall),
		.ex_hold     (ex_hold)
	);

	ex_me u_ex_me (
		.clk                (clk),
		.rst                (rst),
		.stall              (ex_me_stall),
		.ex_valid           (ex_valid),
		.ex_mem_rena        (ex_mem_rena),
		.ex_mem_wena        (ex_mem_wena),
		.ex_mem_ext_un      (ex_mem_ext_un),
		.ex_mem_byte_enable (ex_mem_byte_enable),
		.ex_alu_result      (ex_alu_result),
		.ex_rs2_data        (ex_rs2_data),
		.ex_rd_wena         (ex_rd_wena),
		.ex_rd_waddr        (ex_rd_waddr),
		.ex_pc              (ex_pc),
		.ex_exception_flag  (ex_exception_flag),
		.ex_exception_cause (ex_exception_cause),
		.me_valid           (me_valid),
		.me_mem_rena        (me_mem_rena),
		.me_mem_wena        (me_mem_wena),
		.me_mem_ext_un      (me_mem_ext_un),
		.me_mem_byte_enable (me_mem_byte_enable),
		.me_alu_result      (me_alu_result),
		.me_rs2_data        (me_rs2_data),
		.me_rd_wena         (me_rd_wena),
		.me_rd_waddr        (me_rd_waddr),
		.me_pc              (me_pc),
		.me_exception_flag  (me_exception_flag),
		.me_exception_cause (me_exception_cause)
	);

	mem_access u_mem_access (
		.clk                 (clk),
		.rst                 (rst),
		.me_valid            (me_valid),
		.me_mem_rena         (me_mem_rena),
		.me_mem_wena         (me_mem_wena),
		.me_mem_ext_un       (me_mem_ext_un),
		.me_mem_byte_enable  (me_mem_byte_enable),
		.me_alu_result       (me_alu_result),
		.me_rs2_data         (me_rs2_data),
		.me_rd_wena          (me_rd_wena),
		.me_exception_flag   (me_exception_flag),
		.me_exception_cause  (me_exception_cause),
		.psel                (psel),
		.penable             (penable),
		.pwrite              (pwrite),
		.paddr               (paddr),
		.pwdata              (pwdata),
		.pstrb               (pstrb),
		.prdata              (prdata),
		.pready              (pready),
		.pslverr             (pslverr),
		.mem_busy            (mem_busy),
		.acc_rd_wena         (acc_rd_wena),
		.acc_rd_wdata        (acc_rd_wdata),
		.acc_exception_flag  (acc_exception_flag),
		.acc_exception_cause (acc_exception_cause)
	);

	apb_data_ram u_apb_data_ram (
		.clk     (clk),
		.rst     (rst),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.pstrb   (pstrb),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr)
	);

	me_wb u_me_wb (
		.clk                 (clk),
		.rst                 (rst),
		.stall               (me_wb_stall),
		.me_valid            (me_valid),
		.acc_rd_wena         (acc_rd_wena),
		.me_rd_waddr         (me_rd_waddr),
		.acc_rd_wdata        (acc_rd_wdata),
		.me_pc               (me_pc),
		.acc_exception_flag  (acc_exception_flag),
		.acc_exception_cause (acc_exception_cause),
		.wb_valid            (wb_valid),
		.wb_rd_wena          (wb_rd_wena),
		.wb_rd_waddr         (wb_rd_waddr),
		.wb_rd_wdata         (wb_rd_wdata),
		.wb_pc               (wb_pc),
		.wb_exception_flag   (wb_exception_flag),
		.wb_exception_cause  (wb_exception_cause)
	);

endmodule

// ==== rtl/stall_ctrl.sv ====
`timescale 1ns/1ps

module stall_ctrl import core_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      mem_busy,
	input  logic      flush,
	output stall_op_e ex_me_stall,
	output stall_op_e me_wb_stall,
	output logic      ex_hold
);

	logic flush_pend;

	// a flush seen during a transfer waits for its end
	always_ff @(posedge clk) begin
		if (rst)
			flush_pend <= 1'b0;
		else if (mem_busy)
			flush_pend <= flush_pend | flush;
		else
			flush_pend <= 1'b0;
	end

	always_comb begin
		ex_hold = mem_busy;
		if (mem_busy) begin
			ex_me_stall = STALL_KEEP;
			me_wb_stall = STALL_ZERO;
		end else if (flush || flush_pend) begin
			ex_me_stall = STALL_ZERO;
			me_wb_stall = STALL_NEXT;
		end else begin
			ex_me_stall = STALL_NEXT;
			me_wb_stall = STALL_NEXT;
		end
	end

endmodule

// ==== tests/tb_mem_subsys.sv ====
`timescale 1ns/1ps

module tb_mem_subsys import core_pkg::*; ();

	localparam int NUM_OPS = 80;
	localparam int LIMIT   = NUM_OPS * (4 + DRAM_WAIT) + 300;
	localparam int RAM_BYTES = DRAM_WORDS * 8;

	logic clk;
	logic rst;
	logic ex_valid;
	logic ex_mem_rena;
	logic ex_mem_wena;
	logic ex_mem_ext_un;
	logic [BE_W-1:0] ex_mem_byte_enable;
	logic [XLEN-1:0] ex_alu_result;
	logic [XLEN-1:0] ex_rs2_data;
	logic [XLEN-1:0] ex_pc;
	logic ex_rd_wena;
	logic [REG_ADDR_W-1:0] ex_rd_waddr;
	logic ex_exception_flag;
	logic [CAUSE_W-1:0] ex_exception_cause;
	logic flush;
	logic ex_hold;
	logic wb_valid;
	logic wb_rd_wena;
	logic wb_exception_flag;
	logic [REG_ADDR_W-1:0] wb_rd_waddr;
	logic [XLEN-1:0] wb_rd_wdata;
	logic [XLEN-1:0] wb_pc;
	logic [CAUSE_W-1:0] wb_exception_cause;

	// reference copy of the data RAM
	logic [7:0] ram_model [RAM_BYTES];

	// observed and expected write-back records
	logic [XLEN-1:0] obs_data[$];
	logic [XLEN-1:0] obs_pc[$];
	logic [XLEN-1:0] exp_data[$];
	logic [XLEN-1:0] exp_pc[$];
	logic [15:0] obs_ctl[$];
	logic [15:0] exp_ctl[$];
	bit exp_skip_data[$];

	integer seed = 74;
	int errors = 0;
	int checks = 0;
	int err_mark = 0;
	int cycles = 0;
	int hold_rises = 0;
	logic hold_prev = 1'b0;
	logic [XLEN-1:0] pc_next = 64'h1000;
	int widths [4] = '{1, 2, 4, 8};

	mem_subsys_top DUT (
		.clk(clk), .rst(rst),
		.ex_valid(ex_valid), .ex_mem_rena(ex_mem_rena), .ex_mem_wena(ex_mem_wena),
		.ex_mem_ext_un(ex_mem_ext_un), .ex_mem_byte_enable(ex_mem_byte_enable),
		.ex_alu_result(ex_alu_result), .ex_rs2_data(ex_rs2_data),
		.ex_rd_wena(ex_rd_wena), .ex_rd_waddr(ex_rd_waddr), .ex_pc(ex_pc),
		.ex_exception_flag(ex_exception_flag), .ex_exception_cause(ex_exception_cause),
		.flush(flush), .ex_hold(ex_hold),
		.wb_valid(wb_valid), .wb_rd_wena(wb_rd_wena), .wb_rd_waddr(wb_rd_waddr),
		.wb_rd_wdata(wb_rd_wdata), .wb_pc(wb_pc),
		.wb_exception_flag(wb_exception_flag), .wb_exception_cause(wb_exception_cause)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > LIMIT) begin
			$display("timeout: run exceeded %0d cycles", LIMIT);
			$display("TESTS FAILED");
			$finish;
		end
	end

	// record every write-back and count ex_hold rising edges
	always @(negedge clk) begin
		if (!rst) begin
			if (wb_valid) begin
				obs_data.push_back(wb_rd_wdata);
				obs_pc.push_back(wb_pc);
				obs_ctl.push_back({8'(wb_rd_waddr), wb_rd_wena, wb_exception_flag,
					6'(wb_exception_cause)});
			end
			if (ex_hold && !hold_prev)
				hold_rises++;
			hold_prev = ex_hold;
		end
	end

	task automatic check_val(input string name, input logic [XLEN-1:0] got,
			input logic [XLEN-1:0] exp);
		checks++;
		if (got !== exp) begin
			$display("CHECK FAILED %s: got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic end_test(input string name);
		$display("%s finished with %0d errors", name, errors - err_mark);
		err_mark = errors;
	endtask

	task automatic issue_op(input logic rena, input logic wena, input logic un,
			input logic [BE_W-1:0] be, input logic [XLEN-1:0] alu,
			input logic [XLEN-1:0] rs2, input logic rdw, input logic [4:0] rd,
			input logic fl);
		@(posedge clk);
		ex_valid           <= 1'b1;
		ex_mem_rena        <= rena;
		ex_mem_wena        <= wena;
		ex_mem_ext_un      <= un;
		ex_mem_byte_enable <= be;
		ex_alu_result      <= alu;
		ex_rs2_data        <= rs2;
		ex_rd_wena         <= rdw;
		ex_rd_waddr        <= rd;
		ex_pc              <= pc_next;
		flush              <= fl;
		@(negedge clk);
		while (ex_hold)
			@(negedge clk);
		// captured at the coming edge, then replaced by a bubble
		@(posedge clk);
		ex_valid    <= 1'b0;
		ex_mem_rena <= 1'b0;
		ex_mem_wena <= 1'b0;
		ex_rd_wena  <= 1'b0;
		flush       <= 1'b0;
		pc_next = pc_next + 4;
	endtask

	task automatic expect_wb(input logic [XLEN-1:0] data, input logic [4:0] rd,
			input logic wena, input logic exc, input logic [4:0] cause, input bit skip);
		exp_data.push_back(data);
		exp_pc.push_back(pc_next);
		exp_ctl.push_back({8'(rd), wena, exc, 6'(cause)});
		exp_skip_data.push_back(skip);
	endtask

	task automatic collect_results(input int n);
		logic [15:0] got_ctl;
		logic [15:0] want_ctl;
		for (int k = 0; k < n; k++) begin
			while (obs_pc.size() == 0)
				@(posedge clk);
			got_ctl  = obs_ctl.pop_front();
			want_ctl = exp_ctl.pop_front();
			check_val("wb_pc", obs_pc.pop_front(), exp_pc.pop_front());
			check_val("wb_rd_waddr", got_ctl[15:8], want_ctl[15:8]);
			check_val("wb_rd_wena", got_ctl[7], want_ctl[7]);
			check_val("wb_exception_flag", got_ctl[6], want_ctl[6]);
			if (want_ctl[6])
				check_val("wb_exception_cause", got_ctl[4:0], want_ctl[4:0]);
			if (exp_skip_data.pop_front()) begin
				void'(obs_data.pop_front());
				void'(exp_data.pop_front());
			end else begin
				check_val("wb_rd_wdata", obs_data.pop_front(), exp_data.pop_front());
			end
		end
	endtask

	function automatic logic [XLEN-1:0] load_expect(input int addr, input int n,
			input logic un);
		logic [XLEN-1:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v[i*8 +: 8] = ram_model[addr + i];
		if (!un && n < 8 && v[8*n-1])
			v = v | ~((64'd1 << (8 * n)) - 64'd1);
		return v;
	endfunction

	task automatic alu_op(input logic [XLEN-1:0] value, input logic [4:0] rd,
			input logic fl);
		if (!fl)
			expect_wb(value, rd, 1'b1, 1'b0, 5'd0, 1'b0);
		issue_op(1'b0, 1'b0, 1'b0, '0, value, '0, 1'b1, rd, fl);
	endtask

	task automatic mem_op(input logic st, input logic [XLEN-1:0] addr, input int n,
			input logic [XLEN-1:0] data, input logic un, input logic fl);
		int off;
		logic [BE_W-1:0] be;
		logic misal;
		logic fault;
		logic [4:0] rd;
		off   = addr[2:0];
		be    = 8'(((16'd1 << n) - 16'd1) << off);
		misal = (off % n) != 0;
		fault = addr >= RAM_BYTES;
		rd    = st ? 5'd0 : (5'($random(seed)) | 5'd1);
		if (!fl) begin
			if (misal)
				expect_wb('0, rd, 1'b0, 1'b1, st ? 5'd6 : 5'd4, 1'b1);
			else if (fault)
				expect_wb('0, rd, 1'b0, 1'b1, st ? 5'd7 : 5'd5, 1'b1);
			else if (st)
				expect_wb(addr, rd, 1'b0, 1'b0, 5'd0, 1'b0);
			else
				expect_wb(load_expect(int'(addr), n, un), rd, 1'b1, 1'b0, 5'd0, 1'b0);
		end
		if (st && !misal && !fault) begin
			for (int i = 0; i < n; i++)
				ram_model[int'(addr) + i] = data[i*8 +: 8];
		end
		issue_op(!st, st, un, be, addr, data << (8 * off), !st, rd, fl);
	endtask

	task automatic reset_passthrough();
		check_val("wb_valid", wb_valid, 1'b0);
		check_val("ex_hold", ex_hold, 1'b0);
		alu_op({$random(seed), $random(seed)}, 5'd7, 1'b0);
		collect_results(1);
		end_test("reset and pass-through");
	endtask

	task automatic load_store_widths();
		int base;
		int addr;
		int la;
		for (int w = 0; w < 4; w++) begin
			base = $random(seed) & 32'h7f8;
			addr = base + ($random(seed) & 7 & ~(widths[w] - 1));
			mem_op(1'b1, base, 8, {$random(seed), $random(seed)}, 1'b0, 1'b0);
			mem_op(1'b1, addr, widths[w], {$random(seed), $random(seed)}, 1'b0, 1'b0);
			for (int l = 0; l < 4; l++) begin
				la = base + ((addr - base) & ~(widths[l] - 1));
				mem_op(1'b0, la, widths[l], '0, 1'b0, 1'b0);
				mem_op(1'b0, la, widths[l], '0, 1'b1, 1'b0);
			end
			collect_results(10);
		end
		end_test("load and store widths");
	endtask

	task automatic misaligned_access();
		mem_op(1'b1, 64'h200, 8, {$random(seed), $random(seed)}, 1'b0, 1'b0);
		mem_op(1'b1, 64'h201, 2, 64'hbeef, 1'b0, 1'b0);
		mem_op(1'b1, 64'h202, 4, 64'hdeadcafe, 1'b0, 1'b0);
		mem_op(1'b0, 64'h203, 2, '0, 1'b0, 1'b0);
		mem_op(1'b0, 64'h20a, 4, '0, 1'b1, 1'b0);
		mem_op(1'b0, 64'h200, 8, '0, 1'b0, 1'b0);
		collect_results(6);
		end_test("misaligned access");
	endtask

	task automatic access_fault();
		mem_op(1'b1, 64'h0, 8, {$random(seed), $random(seed)}, 1'b0, 1'b0);
		// index bits alias word 0, so a stray write would show there
		mem_op(1'b1, 64'h1000, 8, 64'h0123456789abcdef, 1'b0, 1'b0);
		mem_op(1'b0, 64'h1008, 4, '0, 1'b0, 1'b0);
		mem_op(1'b0, 64'h0, 8, '0, 1'b0, 1'b0);
		collect_results(4);
		end_test("access fault");
	endtask

	task automatic stall_ordering();
		hold_rises = 0;
		mem_op(1'b1, 64'h300, 8, {$random(seed), $random(seed)}, 1'b0, 1'b0);
		alu_op(64'h11, 5'd3, 1'b0);
		mem_op(1'b0, 64'h300, 4, '0, 1'b0, 1'b0);
		mem_op(1'b0, 64'h304, 2, '0, 1'b1, 1'b0);
		alu_op(64'h22, 5'd4, 1'b0);
		alu_op(64'h33, 5'd5, 1'b0);
		mem_op(1'b1, 64'h308, 1, 64'h5a, 1'b0, 1'b0);
		alu_op(64'h44, 5'd6, 1'b0);
		collect_results(8);
		check_val("ex_hold rises", hold_rises >= 4, 1'b1);
		repeat (4) @(posedge clk);
		check_val("extra wb count", obs_pc.size(), 0);
		end_test("stall ordering");
	endtask

	task automatic flush_squash();
		alu_op(64'h99, 5'd9, 1'b1);
		repeat (6) @(posedge clk);
		check_val("flushed wb count", obs_pc.size(), 0);
		mem_op(1'b0, 64'h300, 8, '0, 1'b0, 1'b0);
		alu_op(64'haa, 5'd10, 1'b1);
		collect_results(1);
		repeat (8) @(posedge clk);
		check_val("squashed wb count", obs_pc.size(), 0);
		end_test("flush");
	endtask

	initial begin
		rst                = 1'b1;
		ex_valid           = 1'b0;
		ex_mem_rena        = 1'b0;
		ex_mem_wena        = 1'b0;
		ex_mem_ext_un      = 1'b0;
		ex_mem_byte_enable = '0;
		ex_alu_result      = '0;
		ex_rs2_data        = '0;
		ex_rd_wena         = 1'b0;
		ex_rd_waddr        = '0;
		ex_pc              = '0;
		ex_exception_flag  = 1'b0;
		ex_exception_cause = '0;
		flush              = 1'b0;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		reset_passthrough();
		load_store_widths();
		misaligned_access();
		access_fault();
		stall_ordering();
		flush_squash();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule
